// File: rtl/rx_data_pkg.sv
/* sample and stream types shared by every stage of the receive chain
   beat geometry is fixed here for the whole design, sample 0 is the oldest */
`default_nettype none

package rx_data_pkg;

  localparam int SAMPLE_WIDTH = 16;     // bits per adc sample
  localparam int PARALLEL_SAMPLES = 2;  // samples per beat per channel

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef sample_t [PARALLEL_SAMPLES-1:0] beat_t; // [0] oldest

  // realtime lane, no ready anywhere upstream of the buffer
  typedef struct packed {
    logic  valid;
    beat_t data;
  } lane_t;

  typedef struct packed {
    lane_t lane;
    logic  keep;  // discriminator verdict for this beat
  } kept_lane_t;

  localparam int DMA_WIDTH = $bits(beat_t); // one beat per dma word

  typedef struct packed {
    logic [DMA_WIDTH-1:0] data;  // beat or header count
    logic                 last;  // final word of the last channel
  } dma_word_t;

endpackage

`default_nettype wire

// File: rtl/rx_cfg_pkg.sv
/* configuration and command types, all already in the adc_clk domain
   index fields are IDX_WIDTH wide, modules use only the bits they need */
`default_nettype none

package rx_cfg_pkg;

  localparam int IDX_WIDTH = 8; // room for any sane channel count

  typedef struct packed {
    rx_data_pkg::sample_t low;   // all samples below -> flag clears
    rx_data_pkg::sample_t high;  // any sample above -> flag sets
  } thresh_t;

  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_START = 2'd1,
    CMD_STOP  = 2'd2
  } cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    CAPTURE,
    READOUT
  } capture_state_t;

  // config writes are strobes, never refused
  typedef struct packed {
    logic                 valid;
    logic [IDX_WIDTH-1:0] channel;  // logical output channel
    logic [IDX_WIDTH-1:0] source;   // 0..2*CHANNELS-1, upper half is differentiated
  } mux_sel_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [IDX_WIDTH-1:0] channel;
    thresh_t              thresh;
  } thresh_wr_t;

endpackage

`default_nettype wire

// File: rtl/sample_differentiator.sv
/* first difference of one channel, one cycle latency
   differences wrap at SAMPLE_WIDTH bits, history only moves on valid beats */
`default_nettype none

module sample_differentiator (
  input  wire                 adc_clk,
  input  wire                 adc_reset,
  input  wire rx_data_pkg::lane_t lane_i,
  output rx_data_pkg::lane_t      lane_o
);

  localparam int PS = rx_data_pkg::PARALLEL_SAMPLES;

  rx_data_pkg::sample_t prev_q;  // newest sample of last valid beat
  rx_data_pkg::beat_t   diff;
  rx_data_pkg::beat_t   data_q;
  logic                 valid_q;

  always_comb begin
    diff[0] = lane_i.data[0] - prev_q; // crosses the beat boundary
    for (int i = 1; i < PS; i++) begin
      diff[i] = lane_i.data[i] - lane_i.data[i-1];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      prev_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= lane_i.valid;
      if (lane_i.valid) begin
        prev_q <= lane_i.data[PS-1];
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (lane_i.valid) begin
      data_q <= diff;
    end
  end

  assign lane_o = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// File: rtl/channel_mux.sv
/* builds CHANNELS logical lanes from 2*CHANNELS inputs, one cycle latency
   select writes take effect on the next cycle, reset maps output k to input k */
`default_nettype none

module channel_mux #(
  parameter int CHANNELS = 2
) (
  input  wire                          adc_clk,
  input  wire                          adc_reset,
  input  wire rx_data_pkg::lane_t      lanes_i [2*CHANNELS],
  input  wire rx_cfg_pkg::mux_sel_wr_t mux_sel_wr_i,
  output rx_data_pkg::lane_t           lanes_o [CHANNELS]
);

  localparam int SEL_WIDTH = $clog2(2*CHANNELS);

  logic [SEL_WIDTH-1:0] sel_q [CHANNELS];  // source per logical channel
  logic [CHANNELS-1:0]  valid_q;
  rx_data_pkg::beat_t   data_q [CHANNELS];

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      for (int k = 0; k < CHANNELS; k++) begin
        sel_q[k] <= SEL_WIDTH'(k); // identity
      end
      valid_q <= '0;
    end else begin
      for (int k = 0; k < CHANNELS; k++) begin
        if (mux_sel_wr_i.valid && int'(mux_sel_wr_i.channel) == k) begin
          sel_q[k] <= mux_sel_wr_i.source[SEL_WIDTH-1:0];
        end
        valid_q[k] <= lanes_i[sel_q[k]].valid;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int k = 0; k < CHANNELS; k++) begin
      data_q[k] <= lanes_i[sel_q[k]].data; // payload, follows valid
    end
  end

  for (genvar k = 0; k < CHANNELS; k++) begin : g_out
    assign lanes_o[k] = '{valid: valid_q[k], data: data_q[k]};
  end

  // a bad source would index past the input array from the next cycle on
  a_sel_range: assert property (@(posedge adc_clk) disable iff (adc_reset)
    mux_sel_wr_i.valid |-> int'(mux_sel_wr_i.source) < 2*CHANNELS);

endmodule

`default_nettype wire

// File: rtl/sample_discriminator.sv
/* per-channel hysteresis gate, one cycle latency, all beats pass with a keep bit
   if high < low a beat that trips both sets the flag */
`default_nettype none

module sample_discriminator #(
  parameter int CHANNELS = 2
) (
  input  wire                         adc_clk,
  input  wire                         adc_reset,
  input  wire rx_data_pkg::lane_t     lanes_i [CHANNELS],
  input  wire rx_cfg_pkg::thresh_wr_t thresh_wr_i,
  output rx_data_pkg::kept_lane_t     lanes_o [CHANNELS]
);

  localparam int PS = rx_data_pkg::PARALLEL_SAMPLES;

  rx_cfg_pkg::thresh_t thresh_q [CHANNELS];
  logic [CHANNELS-1:0] flag_q;    // hysteresis state
  logic [CHANNELS-1:0] any_high;  // some sample above high
  logic [CHANNELS-1:0] all_low;   // every sample below low
  logic [CHANNELS-1:0] valid_q;
  logic [CHANNELS-1:0] keep_q;
  rx_data_pkg::beat_t  data_q [CHANNELS];

  ////////////////////
  // threshold compare
  ////////////////////
  always_comb begin
    for (int k = 0; k < CHANNELS; k++) begin
      any_high[k] = 1'b0;
      all_low[k]  = 1'b1;
      for (int i = 0; i < PS; i++) begin
        if ($signed(lanes_i[k].data[i]) > $signed(thresh_q[k].high)) begin
          any_high[k] = 1'b1;
        end
        if (!($signed(lanes_i[k].data[i]) < $signed(thresh_q[k].low))) begin
          all_low[k] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      for (int k = 0; k < CHANNELS; k++) begin
        thresh_q[k] <= '0;
      end
      flag_q  <= '0;
      valid_q <= '0;
      keep_q  <= '0;
    end else begin
      for (int k = 0; k < CHANNELS; k++) begin
        if (thresh_wr_i.valid && int'(thresh_wr_i.channel) == k) begin
          thresh_q[k] <= thresh_wr_i.thresh;
        end
        valid_q[k] <= lanes_i[k].valid;
        // clearing beat still kept, since flag_q was set before it
        keep_q[k]  <= lanes_i[k].valid && (flag_q[k] || any_high[k]);
        if (lanes_i[k].valid) begin
          if (any_high[k]) begin
            flag_q[k] <= 1'b1;
          end else if (all_low[k]) begin
            flag_q[k] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int k = 0; k < CHANNELS; k++) begin
      data_q[k] <= lanes_i[k].data;
    end
  end

  for (genvar k = 0; k < CHANNELS; k++) begin : g_out
    assign lanes_o[k] = '{lane: '{valid: valid_q[k], data: data_q[k]}, keep: keep_q[k]};
  end

endmodule

`default_nettype wire

// File: rtl/capture_buffer.sv
/* per-channel capture banks, BANK_DEPTH must be a power of two and at least 2
   readout per channel is a count header then that many beats, last on the final word */
`default_nettype none

module capture_buffer #(
  parameter int CHANNELS   = 2,
  parameter int BANK_DEPTH = 16
) (
  input  wire                          adc_clk,
  input  wire                          adc_reset,
  input  wire rx_data_pkg::kept_lane_t lanes_i [CHANNELS],
  input  wire rx_cfg_pkg::cmd_t        cmd_i,
  input  wire                          cmd_valid_i,
  output logic                         cmd_ready_o,
  output rx_data_pkg::dma_word_t       dma_o,
  output logic                         dma_valid_o,
  input  wire                          dma_ready_i,
  output logic                         capture_done_o
);

  localparam int ADDR_WIDTH = $clog2(BANK_DEPTH);
  localparam int CNT_WIDTH  = ADDR_WIDTH + 1;  // holds BANK_DEPTH itself
  localparam int CH_WIDTH   = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
  localparam int DATA_WIDTH = rx_data_pkg::DMA_WIDTH;

  rx_cfg_pkg::capture_state_t state_q;
  rx_data_pkg::beat_t     bank_mem [CHANNELS][BANK_DEPTH];
  logic [CNT_WIDTH-1:0]   count_q [CHANNELS];  // beats stored per bank
  logic [CHANNELS-1:0]    wr_en;
  logic [CHANNELS-1:0]    full;
  logic                   start_fire;
  logic                   stop_fire;
  logic [CH_WIDTH-1:0]    rd_ch_q;       // channel being fetched
  logic [CNT_WIDTH-1:0]   rd_pos_q;      // 0 = header, n = beat n-1
  logic                   fetch_done_q;  // last word already loaded
  logic                   load;
  logic                   fetch_last;
  rx_data_pkg::dma_word_t next_word;

  always_comb begin
    case (cmd_i)
      rx_cfg_pkg::CMD_START: cmd_ready_o = (state_q == rx_cfg_pkg::IDLE);
      rx_cfg_pkg::CMD_STOP:  cmd_ready_o = (state_q == rx_cfg_pkg::CAPTURE);
      default:               cmd_ready_o = 1'b1; // none, taken and dropped
    endcase
  end

  assign start_fire = cmd_valid_i && cmd_ready_o && (cmd_i == rx_cfg_pkg::CMD_START);
  assign stop_fire  = cmd_valid_i && cmd_ready_o && (cmd_i == rx_cfg_pkg::CMD_STOP);

  for (genvar k = 0; k < CHANNELS; k++) begin : g_wr
    assign full[k]  = (count_q[k] == CNT_WIDTH'(BANK_DEPTH));
    assign wr_en[k] = (state_q == rx_cfg_pkg::CAPTURE) && lanes_i[k].lane.valid
                      && lanes_i[k].keep && !full[k];
  end

  always_ff @(posedge adc_clk) begin
    for (int k = 0; k < CHANNELS; k++) begin
      if (wr_en[k]) begin
        bank_mem[k][count_q[k][ADDR_WIDTH-1:0]] <= lanes_i[k].lane.data;
      end
    end
  end

  ////////////////////
  // readout fetch
  ////////////////////
  always_comb begin
    fetch_last = (rd_ch_q == CH_WIDTH'(CHANNELS-1)) && (rd_pos_q == count_q[rd_ch_q]);
    next_word.last = fetch_last;
    if (rd_pos_q == '0) begin
      next_word.data = DATA_WIDTH'(count_q[rd_ch_q]); // header
    end else begin
      next_word.data = bank_mem[rd_ch_q][ADDR_WIDTH'(rd_pos_q - 1'b1)];
    end
  end

  // refill the output register when empty or draining
  assign load = (state_q == rx_cfg_pkg::READOUT) && !fetch_done_q
                && (!dma_valid_o || dma_ready_i);

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state_q        <= rx_cfg_pkg::IDLE;
      rd_ch_q        <= '0;
      rd_pos_q       <= '0;
      fetch_done_q   <= 1'b0;
      dma_valid_o    <= 1'b0;
      capture_done_o <= 1'b0;
      for (int k = 0; k < CHANNELS; k++) begin
        count_q[k] <= '0;
      end
    end else begin
      capture_done_o <= 1'b0;
      case (state_q)
        rx_cfg_pkg::IDLE: begin
          if (start_fire) begin
            state_q <= rx_cfg_pkg::CAPTURE;
            for (int k = 0; k < CHANNELS; k++) begin
              count_q[k] <= '0;
            end
          end
        end
        rx_cfg_pkg::CAPTURE: begin
          for (int k = 0; k < CHANNELS; k++) begin
            if (wr_en[k]) begin
              count_q[k] <= count_q[k] + 1'b1;
            end
          end
          if (stop_fire || |full) begin // a full bank ends capture for all
            state_q      <= rx_cfg_pkg::READOUT;
            rd_ch_q      <= '0;
            rd_pos_q     <= '0;
            fetch_done_q <= 1'b0;
          end
        end
        rx_cfg_pkg::READOUT: begin
          if (load) begin
            dma_valid_o <= 1'b1;
            if (fetch_last) begin
              fetch_done_q <= 1'b1;
            end else if (rd_pos_q == count_q[rd_ch_q]) begin
              rd_ch_q  <= rd_ch_q + 1'b1; // next bank, header first
              rd_pos_q <= '0;
            end else begin
              rd_pos_q <= rd_pos_q + 1'b1;
            end
          end else if (dma_ready_i) begin
            dma_valid_o <= 1'b0;
          end
          if (dma_valid_o && dma_ready_i && dma_o.last) begin
            state_q        <= rx_cfg_pkg::IDLE;
            capture_done_o <= 1'b1;
          end
        end
        default: state_q <= rx_cfg_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge adc_clk) begin
    if (load) begin
      dma_o <= next_word;
    end
  end

  for (genvar k = 0; k < CHANNELS; k++) begin : g_count_chk
    a_count_bound: assert property (@(posedge adc_clk) disable iff (adc_reset)
      count_q[k] <= CNT_WIDTH'(BANK_DEPTH));
  end

  // stalled word must survive until it is taken
  a_dma_hold: assert property (@(posedge adc_clk) disable iff (adc_reset)
    dma_valid_o && !dma_ready_i |=> dma_valid_o && $stable(dma_o));

endmodule

`default_nettype wire

// File: rtl/receive_top.sv
/* receive chain top: differentiator, channel mux, discriminator, capture buffer
   raw lanes reach the banks one cycle earlier than differentiated ones */
`default_nettype none

module receive_top #(
  parameter int CHANNELS   = 2,   // physical and logical channel count
  parameter int BANK_DEPTH = 16   // beats per bank, power of two
) (
  input  wire                          adc_clk,
  input  wire                          adc_reset,
  input  wire rx_data_pkg::lane_t      adc_data_i [CHANNELS],
  input  wire rx_cfg_pkg::mux_sel_wr_t mux_sel_wr_i,
  input  wire rx_cfg_pkg::thresh_wr_t  thresh_wr_i,
  input  wire rx_cfg_pkg::cmd_t        cmd_i,
  input  wire                          cmd_valid_i,
  output logic                         cmd_ready_o,
  output rx_data_pkg::dma_word_t       dma_o,
  output logic                         dma_valid_o,
  input  wire                          dma_ready_i,
  output logic                         capture_done_o
);

  wire rx_data_pkg::lane_t      mux_in   [2*CHANNELS];  // raw low, differentiated high
  wire rx_data_pkg::lane_t      mux_out  [CHANNELS];
  wire rx_data_pkg::kept_lane_t disc_out [CHANNELS];

  ////////////////////
  // physical lanes
  ////////////////////
  for (genvar k = 0; k < CHANNELS; k++) begin : g_phys
    assign mux_in[k] = adc_data_i[k];

    sample_differentiator i_sample_differentiator (
      .adc_clk   (adc_clk),
      .adc_reset (adc_reset),
      .lane_i    (adc_data_i[k]),
      .lane_o    (mux_in[CHANNELS+k])  // input CHANNELS+k is diff of k
    );
  end

  channel_mux #(
    .CHANNELS (CHANNELS)
  ) i_channel_mux (
    .adc_clk      (adc_clk),
    .adc_reset    (adc_reset),
    .lanes_i      (mux_in),
    .mux_sel_wr_i (mux_sel_wr_i),
    .lanes_o      (mux_out)
  );

  sample_discriminator #(
    .CHANNELS (CHANNELS)
  ) i_sample_discriminator (
    .adc_clk     (adc_clk),
    .adc_reset   (adc_reset),
    .lanes_i     (mux_out),
    .thresh_wr_i (thresh_wr_i),
    .lanes_o     (disc_out)
  );

  capture_buffer #(
    .CHANNELS   (CHANNELS),
    .BANK_DEPTH (BANK_DEPTH)
  ) i_capture_buffer (
    .adc_clk        (adc_clk),
    .adc_reset      (adc_reset),
    .lanes_i        (disc_out),
    .cmd_i          (cmd_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .dma_o          (dma_o),
    .dma_valid_o    (dma_valid_o),
    .dma_ready_i    (dma_ready_i),
    .capture_done_o (capture_done_o)
  );

endmodule

`default_nettype wire

// File: bench/receive_tb.sv
/* directed tests for receive_top with a beat-level reference model
   stimulus and dma stalls come from an lfsr, inputs change 1 unit after the rising edge */
`default_nettype none

module receive_tb;

  localparam int CHANNELS     = 2;
  localparam int BANK_DEPTH   = 16;
  localparam int PS           = rx_data_pkg::PARALLEL_SAMPLES;
  localparam int IW           = rx_cfg_pkg::IDX_WIDTH;
  localparam int DW           = rx_data_pkg::DMA_WIDTH;
  localparam int MAX_WORDS    = CHANNELS * (BANK_DEPTH + 1);
  localparam int CMD_TIMEOUT  = 100;   // cycles
  localparam int READ_TIMEOUT = 2000;  // cycles
  localparam int MODE_RAND    = 0;     // full range samples
  localparam int MODE_POS     = 1;     // non-negative samples
  localparam int MODE_RAMP    = 2;     // up then down ramp

  logic                    adc_clk;
  logic                    adc_reset;
  rx_data_pkg::lane_t      adc_data [CHANNELS];
  rx_cfg_pkg::mux_sel_wr_t mux_sel_wr;
  rx_cfg_pkg::thresh_wr_t  thresh_wr;
  rx_cfg_pkg::cmd_t        cmd;
  logic                    cmd_valid;
  logic                    cmd_ready;
  rx_data_pkg::dma_word_t  dma;
  logic                    dma_valid;
  logic                    dma_ready;
  logic                    capture_done;

  logic [31:0] lfsr_state;
  int          errors;
  int          timeouts;

  // reference model state
  rx_data_pkg::sample_t model_prev [CHANNELS];  // newest raw sample per physical channel
  int                   model_sel  [CHANNELS];
  int                   model_lo   [CHANNELS];
  int                   model_hi   [CHANNELS];
  logic                 model_flag [CHANNELS];
  logic                 cap_on;                   // buffer taking beats
  rx_data_pkg::beat_t   cur_raw    [CHANNELS];    // beats of this cycle
  rx_data_pkg::beat_t   exp_mem    [CHANNELS][BANK_DEPTH];
  int                   exp_cnt    [CHANNELS];
  int                   hdr_seen   [CHANNELS];    // headers of the last readout

  receive_top #(
    .CHANNELS   (CHANNELS),
    .BANK_DEPTH (BANK_DEPTH)
  ) i_receive_top (
    .adc_clk        (adc_clk),
    .adc_reset      (adc_reset),
    .adc_data_i     (adc_data),
    .mux_sel_wr_i   (mux_sel_wr),
    .thresh_wr_i    (thresh_wr),
    .cmd_i          (cmd),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .dma_o          (dma),
    .dma_valid_o    (dma_valid),
    .dma_ready_i    (dma_ready),
    .capture_done_o (capture_done)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]; // x^32+x^22+x^2+x+1
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("** Error at time %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string msg);
    timeouts++;
    $display("Timeout at time %0t: %s", $time, msg);
  endtask

  function automatic rx_data_pkg::beat_t make_beat(input int mode, input int i, input int p);
    rx_data_pkg::beat_t b;
    int j;
    int v;
    for (int s = 0; s < PS; s++) begin
      j = PS * i + s;  // sample index in the whole burst
      if (mode == MODE_RAMP) begin
        v = (j < 20) ? -200 + 30 * j : 370 - 40 * (j - 19);
        b[s] = rx_data_pkg::sample_t'(v - 20 * p); // channel offset
      end else if (mode == MODE_POS) begin
        b[s] = rx_data_pkg::sample_t'(take_bits(15));
      end else begin
        b[s] = rx_data_pkg::sample_t'(take_bits(16));
      end
    end
    return b;
  endfunction

  // one cycle of valid beats through difference, select, hysteresis, bank fill
  function automatic void model_cycle();
    rx_data_pkg::beat_t diff [CHANNELS];
    rx_data_pkg::beat_t b;
    logic               hi;
    logic               lo;
    logic               keep;
    int                 src;
    for (int p = 0; p < CHANNELS; p++) begin
      diff[p][0] = cur_raw[p][0] - model_prev[p];  // wraps at 16 bits
      for (int s = 1; s < PS; s++) begin
        diff[p][s] = cur_raw[p][s] - cur_raw[p][s-1];
      end
      model_prev[p] = cur_raw[p][PS-1];
    end
    for (int k = 0; k < CHANNELS; k++) begin
      src = model_sel[k];
      b   = (src < CHANNELS) ? cur_raw[src] : diff[src-CHANNELS];
      hi  = 1'b0;
      lo  = 1'b1;
      for (int s = 0; s < PS; s++) begin
        if (int'($signed(b[s])) > model_hi[k]) hi = 1'b1;
        if (!(int'($signed(b[s])) < model_lo[k])) lo = 1'b0;
      end
      keep = model_flag[k] || hi;
      if (hi) model_flag[k] = 1'b1;
      else if (lo) model_flag[k] = 1'b0;
      if (cap_on && keep && exp_cnt[k] < BANK_DEPTH) begin
        exp_mem[k][exp_cnt[k]] = b;
        exp_cnt[k]++;
      end
    end
  endfunction

  task automatic select_source(input int ch, input int src);
    @(posedge adc_clk);
    #1;
    mux_sel_wr.valid   = 1'b1;
    mux_sel_wr.channel = IW'(ch);
    mux_sel_wr.source  = IW'(src);
    @(posedge adc_clk);
    #1;
    mux_sel_wr.valid = 1'b0;
    model_sel[ch]    = src;
  endtask

  task automatic set_thresholds(input int ch, input int lo, input int hi);
    @(posedge adc_clk);
    #1;
    thresh_wr.valid       = 1'b1;
    thresh_wr.channel     = IW'(ch);
    thresh_wr.thresh.low  = rx_data_pkg::sample_t'(lo);
    thresh_wr.thresh.high = rx_data_pkg::sample_t'(hi);
    @(posedge adc_clk);
    #1;
    thresh_wr.valid = 1'b0;
    model_lo[ch]    = lo;
    model_hi[ch]    = hi;
  endtask

  task automatic send_cmd(input rx_cfg_pkg::cmd_t c);
    int t;
    @(posedge adc_clk);
    #1;
    cmd       = c;
    cmd_valid = 1'b1;
    t         = 0;
    #1;
    while (!cmd_ready && t < CMD_TIMEOUT) begin
      @(posedge adc_clk);
      #2;
      t++;
    end
    if (!cmd_ready) begin
      report_timeout($sformatf("command %0d never accepted", c));
    end
    @(posedge adc_clk);  // transfer happens here
    #1;
    cmd_valid = 1'b0;
    cmd       = rx_cfg_pkg::CMD_NONE;
    if (c == rx_cfg_pkg::CMD_START) begin
      cap_on = 1'b1;
      for (int k = 0; k < CHANNELS; k++) exp_cnt[k] = 0;
    end else if (c == rx_cfg_pkg::CMD_STOP) begin
      cap_on = 1'b0;
    end
  endtask

  task automatic stream_beats(input int n, input int mode);
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      #1;
      for (int p = 0; p < CHANNELS; p++) begin
        cur_raw[p]  = make_beat(mode, i, p);
        adc_data[p] = '{valid: 1'b1, data: cur_raw[p]};
      end
      model_cycle();
    end
    @(posedge adc_clk);
    #1;
    for (int p = 0; p < CHANNELS; p++) adc_data[p] = '0;
    repeat (6) @(posedge adc_clk);  // pipeline is 4 deep
    #1;
  endtask

  // collects the whole dma stream and checks it word by word
  task automatic read_stream(input bit stall, input bit probe);
    rx_data_pkg::dma_word_t exp_words [MAX_WORDS];
    int                     word_ch   [MAX_WORDS];  // header owner, -1 for data
    int                     n;
    int                     got;
    int                     t;
    bit                     probed;
    n      = 0;
    got    = 0;
    t      = 0;
    probed = 1'b0;
    for (int k = 0; k < CHANNELS; k++) begin
      exp_words[n] = '{data: DW'(exp_cnt[k]), last: 1'b0};
      word_ch[n]   = k;
      n++;
      for (int i = 0; i < exp_cnt[k]; i++) begin
        exp_words[n] = '{data: exp_mem[k][i], last: 1'b0};
        word_ch[n]   = -1;
        n++;
      end
    end
    exp_words[n-1].last = 1'b1;
    while (got < n && t < READ_TIMEOUT) begin
      @(posedge adc_clk);
      #1;
      cmd_valid = 1'b0;
      cmd       = rx_cfg_pkg::CMD_NONE;
      dma_ready = stall ? (take_bits(2) != 0) : 1'b1;  // ~3/4 ready when stalling
      if (probe && !probed && got == 1) begin
        cmd       = rx_cfg_pkg::CMD_START;
        cmd_valid = 1'b1;
        probed    = 1'b1;
        #2;
        if (cmd_ready) report_error("start accepted during readout");
      end
      if (capture_done) report_error("capture_done_o before the last word");
      if (dma_valid && dma_ready) begin
        if (dma !== exp_words[got]) begin
          report_error($sformatf("word %0d got data %h last %b, expected data %h last %b",
                                 got, dma.data, dma.last,
                                 exp_words[got].data, exp_words[got].last));
        end
        if (word_ch[got] >= 0) hdr_seen[word_ch[got]] = int'(dma.data);
        got++;
      end
      t++;
    end
    if (got < n) begin
      report_timeout($sformatf("readout stalled after %0d of %0d words", got, n));
    end
    @(posedge adc_clk);
    #1;
    dma_ready = 1'b0;
    if (capture_done !== 1'b1) report_error("no capture_done_o pulse after last word");
    @(posedge adc_clk);
    #1;
    if (capture_done !== 1'b0) report_error("capture_done_o longer than one cycle");
    if (dma_valid !== 1'b0) report_error("dma_valid_o still high after readout");
  endtask

  ////////////////////
  // directed tests
  ////////////////////
  task automatic identity_passthrough();
    for (int k = 0; k < CHANNELS; k++) begin
      set_thresholds(k, -32768, -1);
      select_source(k, k);
    end
    send_cmd(rx_cfg_pkg::CMD_START);
    stream_beats(12, MODE_RAND);
    send_cmd(rx_cfg_pkg::CMD_STOP);
    read_stream(1'b0, 1'b0);
  endtask

  task automatic differentiated_routing();
    for (int k = 0; k < CHANNELS; k++) select_source(k, CHANNELS + k);
    send_cmd(rx_cfg_pkg::CMD_START);
    stream_beats(12, MODE_RAND);
    send_cmd(rx_cfg_pkg::CMD_STOP);
    read_stream(1'b0, 1'b0);
  endtask

  task automatic hysteresis_gate();
    for (int k = 0; k < CHANNELS; k++) begin
      select_source(k, k);
      set_thresholds(k, -100, 100);
    end
    send_cmd(rx_cfg_pkg::CMD_START);
    stream_beats(20, MODE_RAMP);
    send_cmd(rx_cfg_pkg::CMD_STOP);
    read_stream(1'b0, 1'b0);
  endtask

  task automatic bank_full_stop();
    bit any_full;
    any_full = 1'b0;
    for (int k = 0; k < CHANNELS; k++) set_thresholds(k, -32768, -1);
    send_cmd(rx_cfg_pkg::CMD_START);
    stream_beats(BANK_DEPTH + 8, MODE_POS);  // no stop, full bank ends capture
    read_stream(1'b0, 1'b0);
    for (int k = 0; k < CHANNELS; k++) begin
      if (hdr_seen[k] > BANK_DEPTH) begin
        report_error($sformatf("bank %0d count %0d over depth", k, hdr_seen[k]));
      end
      if (hdr_seen[k] == BANK_DEPTH) any_full = 1'b1;
    end
    if (!any_full) report_error("no bank holds exactly BANK_DEPTH beats");
  endtask

  task automatic backpressure_handshake();
    send_cmd(rx_cfg_pkg::CMD_START);
    stream_beats(10, MODE_RAND);
    send_cmd(rx_cfg_pkg::CMD_STOP);
    read_stream(1'b1, 1'b1);
    send_cmd(rx_cfg_pkg::CMD_START);  // back in IDLE, must be taken
    send_cmd(rx_cfg_pkg::CMD_STOP);
    read_stream(1'b1, 1'b0);          // counts cleared, headers only
  endtask

  initial begin
    lfsr_state = 32'h2912;
    errors     = 0;
    timeouts   = 0;
    adc_reset  = 1'b1;
    cmd        = rx_cfg_pkg::CMD_NONE;
    cmd_valid  = 1'b0;
    dma_ready  = 1'b0;
    mux_sel_wr = '0;
    thresh_wr  = '0;
    cap_on     = 1'b0;
    for (int k = 0; k < CHANNELS; k++) begin
      adc_data[k]   = '0;
      model_prev[k] = '0;
      model_sel[k]  = k;   // identity after reset
      model_lo[k]   = 0;
      model_hi[k]   = 0;
      model_flag[k] = 1'b0;
      exp_cnt[k]    = 0;
      hdr_seen[k]   = 0;
    end
    repeat (16) @(posedge adc_clk);
    #1;
    adc_reset = 1'b0;

    identity_passthrough();
    differentiated_routing();
    hysteresis_gate();
    bank_full_stop();
    backpressure_handshake();

    $display("value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
rtl/rx_data_pkg.sv
rtl/rx_cfg_pkg.sv
rtl/sample_differentiator.sv
rtl/channel_mux.sv
rtl/sample_discriminator.sv
rtl/capture_buffer.sv
rtl/receive_top.sv
bench/receive_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the receive chain testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module receive_tb -o receive_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/receive_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
